// File: build.f
src/isa_pkg.sv
src/ctrl_pkg.sv
src/core_ctrl_if.sv
src/alu.sv
src/reg_file.sv
src/program_counter.sv
src/core_control.sv
src/datapath.sv
src/risc16_top.sv
sim/tb_risc16.sv

// File: Bender.yml
package:
  name: risc16

sources:
  - src/isa_pkg.sv
  - src/ctrl_pkg.sv
  - src/core_ctrl_if.sv
  - src/alu.sv
  - src/reg_file.sv
  - src/program_counter.sv
  - src/core_control.sv
  - src/datapath.sv
  - src/risc16_top.sv
  - target: simulation
    files:
      - sim/tb_risc16.sv

// File: sim/tb_risc16.sv
module tb_risc16
    import isa_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_STEPS    = 400;  // Reference model step bound
    localparam int TIMEOUT      = 2000; // Cycles allowed for all stores
    localparam int QUIET_CYCLES = 60;

    logic      clk;
    logic      rst;
    word_t     mem_rdata;
    mem_addr_t mem_addr;
    word_t     mem_wdata;
    logic      mem_wr;

    word_t     mem [256];
    word_t     ref_mem [256];
    mem_addr_t exp_addr [$];
    word_t     exp_data [$];
    integer    seed;
    int        load_ptr;
    int        errors;
    int        checks;
    int        store_idx;
    int        exp_count;
    int        cycles;

    risc16_top DUT (
        .clk         (clk),
        .rst         (rst),
        .mem_rdata_i (mem_rdata),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_wr_o    (mem_wr)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////
    assign mem_rdata = mem[mem_addr]; // Combinational read

    always @(posedge clk) begin
        if (mem_wr === 1'b1) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    function automatic word_t encode_reg(input opcode_e op, input reg_addr_t rd,
                                         input reg_addr_t rp, input reg_addr_t rq);
        return {op, rd, rp, rq};
    endfunction

    function automatic word_t encode_imm(input opcode_e op, input reg_addr_t rd,
                                         input logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    task automatic place_instr(input word_t instr);
        mem[load_ptr] = instr;
        load_ptr++;
    endtask

    task automatic check_equal(input word_t actual, input word_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model of the ISA
    //////////////////////////////////////////////////
    function automatic int run_reference();
        word_t       regs [16];
        logic [7:0]  pc;
        word_t       instr;
        opcode_e     op;
        reg_addr_t   rd;
        reg_addr_t   rp;
        reg_addr_t   rq;
        logic [7:0]  imm;
        logic [7:0]  next_pc;
        int          n;
        n  = 0;
        pc = '0;
        foreach (regs[i]) regs[i] = '0;
        for (int step = 0; step < MAX_STEPS; step++) begin
            instr   = ref_mem[pc];
            op      = opcode_e'(instr[15:12]);
            rd      = instr[11:8];
            rp      = instr[7:4];
            rq      = instr[3:0];
            imm     = instr[7:0];
            next_pc = pc + 8'd1;
            if (op == JMP && imm == 8'd0) break; // Self-loop ends the program
            case (op)
                ADD: regs[rd] = regs[rp] + regs[rq];
                SUB: regs[rd] = regs[rp] - regs[rq];
                AND: regs[rd] = regs[rp] & regs[rq];
                OR:  regs[rd] = regs[rp] | regs[rq];
                XOR: regs[rd] = regs[rp] ^ regs[rq];
                NOT: regs[rd] = ~regs[rp];
                SLA: regs[rd] = {regs[rp][14:0], 1'b0};
                SRA: regs[rd] = {1'b0, regs[rp][15:1]};
                LI:  regs[rd] = {{8{imm[7]}}, imm};
                LW:  regs[rd] = ref_mem[imm];
                SW: begin
                    ref_mem[imm] = regs[rd];
                    exp_addr.push_back(imm);
                    exp_data.push_back(regs[rd]);
                    n++;
                end
                BIZ: if (regs[rd] == '0) next_pc = pc + imm;
                BNZ: if (regs[rd] != '0) next_pc = pc + imm;
                JAL: begin
                    regs[rd] = {8'h00, pc + 8'd1};
                    next_pc  = pc + imm;
                end
                JMP: next_pc = pc + imm;
                JR:  next_pc = regs[rp][7:0];
                default: ;
            endcase
            pc = next_pc;
        end
        return n;
    endfunction

    // Store checker samples mid-cycle
    always @(negedge clk) begin
        if (rst === 1'b0 && mem_wr === 1'b1) begin
            if (store_idx < exp_count) begin
                check_equal(word_t'(mem_addr), word_t'(exp_addr[store_idx]), "store address");
                check_equal(mem_wdata, exp_data[store_idx], "store data");
            end else begin
                errors++;
                $display("Unexpected store at %0t ns to address %h", $time, mem_addr);
            end
            store_idx++;
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        seed      = 11337;
        errors    = 0;
        checks    = 0;
        store_idx = 0;
        exp_count = 0;
        load_ptr  = 0;
        foreach (mem[i]) mem[i] = {~8'(i), 8'(i)};
        for (int k = 0; k < 2; k++) mem[8'hA0 + k] = word_t'($random(seed));

        // ALU block on two random operands
        place_instr(encode_imm(LW, 4'd1, 8'hA0));
        place_instr(encode_imm(LW, 4'd2, 8'hA1));
        for (int k = 0; k < 8; k++) begin
            place_instr(encode_reg(opcode_e'(k), 4'd3, 4'd1, 4'd2));
            place_instr(encode_imm(SW, 4'd3, 8'hC0 + 8'(k)));
        end
        place_instr(encode_imm(LI, 4'd4, 8'h85)); // Negative immediate
        place_instr(encode_imm(SW, 4'd4, 8'hD0));
        place_instr(encode_imm(LI, 4'd5, 8'h3C));
        place_instr(encode_imm(SW, 4'd5, 8'hD1));
        place_instr(encode_imm(LI, 4'd6, 8'h00));
        // Branches taken and not taken
        place_instr(encode_imm(BIZ, 4'd6, 8'd2));
        place_instr(encode_imm(SW, 4'd4, 8'hD2));
        place_instr(encode_imm(SW, 4'd5, 8'hD3));
        place_instr(encode_imm(BIZ, 4'd5, 8'd2));
        place_instr(encode_imm(SW, 4'd5, 8'hD4));
        place_instr(encode_imm(BNZ, 4'd5, 8'd2));
        place_instr(encode_imm(SW, 4'd4, 8'hD5));
        place_instr(encode_imm(BNZ, 4'd6, 8'd2));
        place_instr(encode_imm(SW, 4'd4, 8'hD6));
        // Call, return and forward jump
        place_instr(encode_imm(JAL, 4'd7, 8'd3));
        place_instr(encode_imm(SW, 4'd7, 8'hD7));
        place_instr(encode_imm(JMP, 4'd0, 8'd3));
        place_instr(encode_reg(JR, 4'd0, 4'd7, 4'd0));
        place_instr(encode_imm(SW, 4'd4, 8'hD8));
        place_instr(encode_imm(SW, 4'd6, 8'hD9));
        place_instr(encode_imm(JMP, 4'd0, 8'd0));

        ref_mem   = mem;
        exp_count = run_reference();

        repeat (5) begin
            @(negedge clk);
            check_equal(word_t'(mem_wr), '0, "mem_wr_o during reset");
        end
        rst <= 1'b0;
        check_equal(word_t'(mem_addr), '0, "first fetch address");

        cycles = 0;
        while (store_idx < exp_count && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (store_idx < exp_count) begin
            errors++;
            $display("Timed out: only %0d of %0d expected stores seen", store_idx, exp_count);
        end

        repeat (QUIET_CYCLES) @(negedge clk); // Quiet window after the self-loop
        for (int i = 0; i < 256; i++) begin
            check_equal(mem[i], ref_mem[i], $sformatf("memory word %h", 8'(i)));
        end

        $display("Checks: %0d, stores: %0d of %0d, errors: %0d",
                 checks, store_idx, exp_count, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: src/risc16_top.sv
module risc16_top
    import isa_pkg::*, ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     mem_rdata_i,
    output mem_addr_t mem_addr_o,
    output word_t     mem_wdata_o,
    output logic      mem_wr_o
);

    pc_op_e    pc_op;
    mem_addr_t pc;
    mem_addr_t jr_target;

    //////////////////////////////////////////////////
    // Control word between FSM and datapath
    //////////////////////////////////////////////////
    core_ctrl_if u_ctrl_if ();

    core_control u_core_control (
        .clk     (clk),
        .rst     (rst),
        .instr_i (mem_rdata_i), // Captured in FETCH
        .pc_op_o (pc_op),
        .ctrl    (u_ctrl_if.ctrl)
    );

    program_counter u_program_counter (
        .clk      (clk),
        .rst      (rst),
        .pc_op_i  (pc_op),
        .offset_i (u_ctrl_if.imm),
        .target_i (jr_target),
        .pc_o     (pc)
    );

    datapath u_datapath (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (u_ctrl_if.dp),
        .pc_i        (pc),
        .mem_rdata_i (mem_rdata_i),
        .jr_target_o (jr_target),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_wr_o    (mem_wr_o)
    );

endmodule

// File: src/datapath.sv
module datapath
    import isa_pkg::*, ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    core_ctrl_if.dp   ctrl,
    input  mem_addr_t pc_i,
    input  word_t     mem_rdata_i,
    output mem_addr_t jr_target_o,
    output mem_addr_t mem_addr_o,
    output word_t     mem_wdata_o,
    output logic      mem_wr_o
);

    word_t p_data;
    word_t q_data;
    word_t p_q;
    word_t q_q;
    word_t alu_y;
    word_t wb_data;

    reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .we_i      (ctrl.rf_we),
        .wr_addr_i (ctrl.wr_addr),
        .wr_data_i (wb_data),
        .p_addr_i  (ctrl.p_addr),
        .q_addr_i  (ctrl.q_addr),
        .p_data_o  (p_data),
        .q_data_o  (q_data)
    );

    // Operand latches load in DECODE
    always_ff @(posedge clk) begin
        if (ctrl.operand_ld) begin
            p_q <= p_data;
            q_q <= q_data;
        end
    end

    alu u_alu (.a_i(p_q), .b_i(q_q), .op_i(ctrl.alu_op), .y_o(alu_y));

    always_comb begin
        case (ctrl.wb_sel)
            WB_ALU:  wb_data = alu_y;
            WB_MEM:  wb_data = mem_rdata_i;
            WB_IMM:  wb_data = {{(WORD_W-IMM_W){ctrl.imm[IMM_W-1]}}, ctrl.imm};
            WB_LINK: wb_data = word_t'(pc_i);
            default: wb_data = alu_y;
        endcase
    end

    assign ctrl.p_zero = (p_q == '0);
    assign jr_target_o = p_q[MEM_AW-1:0];

    // Memory port
    assign mem_addr_o  = ctrl.mem_sel ? mem_addr_t'(ctrl.imm) : pc_i;
    assign mem_wdata_o = p_q; // rd value for SW
    assign mem_wr_o    = ctrl.mem_wr;

endmodule

// File: src/core_control.sv
module core_control
    import isa_pkg::*, ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     instr_i,
    output pc_op_e    pc_op_o,
    core_ctrl_if.ctrl ctrl
);

    state_e    state_q;
    state_e    state_d;
    word_t     ir_q;
    opcode_e   opcode;
    reg_addr_t rd;
    reg_addr_t rp;
    reg_addr_t rq;
    logic      p_is_rd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= S_FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (state_q == S_FETCH) begin
            ir_q <= instr_i;
        end
    end

    assign opcode  = opcode_e'(ir_q[OPC_LSB +: $bits(opcode_e)]);
    assign rd      = ir_q[RD_LSB +: REG_AW];
    assign rp      = ir_q[RP_LSB +: REG_AW];
    assign rq      = ir_q[RQ_LSB +: REG_AW];
    assign p_is_rd = opcode inside {SW, BIZ, BNZ}; // These test or store rd

    //////////////////////////////////////////////////
    // FSM and decode
    //////////////////////////////////////////////////
    always_comb begin
        state_d         = S_FETCH;
        pc_op_o         = PC_HOLD;
        ctrl.wr_addr    = rd;
        ctrl.p_addr     = p_is_rd ? rd : rp;
        ctrl.q_addr     = rq;
        ctrl.rf_we      = 1'b0;
        ctrl.operand_ld = 1'b0;
        ctrl.alu_op     = alu_op_e'(ir_q[OPC_LSB +: $bits(alu_op_e)]);
        ctrl.wb_sel     = WB_ALU;
        ctrl.imm        = ir_q[IMM_W-1:0];
        ctrl.mem_sel    = 1'b0;
        ctrl.mem_wr     = 1'b0;

        case (state_q)
            S_FETCH: begin
                state_d = S_DECODE;
                pc_op_o = PC_INC;
            end
            S_DECODE: begin
                state_d         = S_EXECUTE;
                ctrl.operand_ld = 1'b1;
            end
            S_EXECUTE: begin
                state_d = S_FETCH;
                case (opcode)
                    ADD, SUB, AND, OR, XOR, NOT, SLA, SRA: begin
                        ctrl.rf_we  = 1'b1;
                        ctrl.wb_sel = WB_ALU;
                    end
                    LI: begin
                        ctrl.rf_we  = 1'b1;
                        ctrl.wb_sel = WB_IMM;
                    end
                    LW: begin
                        ctrl.rf_we   = 1'b1;
                        ctrl.wb_sel  = WB_MEM;
                        ctrl.mem_sel = 1'b1;
                    end
                    SW: begin
                        ctrl.mem_sel = 1'b1;
                        ctrl.mem_wr  = 1'b1;
                    end
                    BIZ:     pc_op_o = ctrl.p_zero ? PC_REL : PC_HOLD;
                    BNZ:     pc_op_o = ctrl.p_zero ? PC_HOLD : PC_REL;
                    JAL: begin
                        ctrl.rf_we  = 1'b1;
                        ctrl.wb_sel = WB_LINK; // PC is already address plus one
                        pc_op_o     = PC_REL;
                    end
                    JMP:     pc_op_o = PC_REL;
                    JR:      pc_op_o = PC_ABS;
                    default: pc_op_o = PC_HOLD;
                endcase
            end
            default: state_d = S_FETCH;
        endcase
    end

endmodule

// File: src/program_counter.sv
module program_counter
    import isa_pkg::*, ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  pc_op_e    pc_op_i,
    input  imm_t      offset_i,
    input  mem_addr_t target_i,
    output mem_addr_t pc_o
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_o <= '0;
        end else begin
            case (pc_op_i)
                PC_INC: begin
                    pc_o <= pc_o + mem_addr_t'(1);
                end
                PC_REL: begin
                    // PC already points one past the instruction
                    pc_o <= pc_o + mem_addr_t'(offset_i) - mem_addr_t'(1);
                end
                PC_ABS: begin
                    pc_o <= target_i;
                end
                default: pc_o <= pc_o;
            endcase
        end
    end

endmodule

// File: src/reg_file.sv
module reg_file
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      we_i,
    input  reg_addr_t wr_addr_i,
    input  word_t     wr_data_i,
    input  reg_addr_t p_addr_i,
    input  reg_addr_t q_addr_i,
    output word_t     p_data_o,
    output word_t     q_data_o
);

    word_t regs_q [NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs_q <= '{default: '0};
        end else if (we_i) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Asynchronous read ports
    assign p_data_o = regs_q[p_addr_i];
    assign q_data_o = regs_q[q_addr_i];

endmodule

// File: src/alu.sv
module alu
    import isa_pkg::*;
(
    input  word_t   a_i,
    input  word_t   b_i,
    input  alu_op_e op_i,
    output word_t   y_o
);

    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_XOR: y_o = a_i ^ b_i;
            ALU_NOT: y_o = ~a_i;
            ALU_SLA: y_o = a_i << 1;
            ALU_SRA: y_o = a_i >> 1; // Logical with zero fill
            default: y_o = '0;
        endcase
    end

endmodule

// File: src/core_ctrl_if.sv
interface core_ctrl_if
    import isa_pkg::*, ctrl_pkg::*;
();

    reg_addr_t wr_addr;
    reg_addr_t p_addr;
    reg_addr_t q_addr;
    logic      rf_we;
    logic      operand_ld; // Load P and Q latches
    alu_op_e   alu_op;
    wb_sel_e   wb_sel;
    imm_t      imm;
    logic      mem_sel;    // Data address instead of PC
    logic      mem_wr;
    logic      p_zero;

    modport ctrl (
        output wr_addr, p_addr, q_addr, rf_we, operand_ld,
        output alu_op, wb_sel, imm, mem_sel, mem_wr,
        input  p_zero
    );

    modport dp (
        input  wr_addr, p_addr, q_addr, rf_we, operand_ld,
        input  alu_op, wb_sel, imm, mem_sel, mem_wr,
        output p_zero
    );

endinterface

// File: src/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [1:0] {
        S_FETCH   = 2'd0,
        S_DECODE  = 2'd1,
        S_EXECUTE = 2'd2
    } state_e;

    typedef enum logic [1:0] {
        PC_HOLD = 2'd0,
        PC_INC  = 2'd1,
        PC_REL  = 2'd2, // Branch and jump offset
        PC_ABS  = 2'd3  // JR target
    } pc_op_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_IMM  = 2'd2,
        WB_LINK = 2'd3
    } wb_sel_e;

endpackage

// File: src/isa_pkg.sv
package isa_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int WORD_W   = 16;
    localparam int REG_AW   = 4;
    localparam int MEM_AW   = 8;
    localparam int IMM_W    = 8;
    localparam int NUM_REGS = 16;

    // Instruction fields opc | rd | rp | rq with imm in the low byte
    localparam int OPC_LSB = 12;
    localparam int RD_LSB  = 8;
    localparam int RP_LSB  = 4;
    localparam int RQ_LSB  = 0;

    typedef logic [WORD_W-1:0] word_t;     // Data and instruction word
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [MEM_AW-1:0] mem_addr_t; // Memory and program address
    typedef logic [IMM_W-1:0]  imm_t;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ADD = 4'd0,  SUB = 4'd1,  AND = 4'd2,  OR  = 4'd3,
        XOR = 4'd4,  NOT = 4'd5,  SLA = 4'd6,  SRA = 4'd7,
        LI  = 4'd8,  LW  = 4'd9,  SW  = 4'd10, BIZ = 4'd11,
        BNZ = 4'd12, JAL = 4'd13, JMP = 4'd14, JR  = 4'd15
    } opcode_e;

    // Same as low three opcode bits
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_NOT = 3'd5,
        ALU_SLA = 3'd6,
        ALU_SRA = 3'd7
    } alu_op_e;

endpackage
